//--- Bender.yml
package:
  name: rtc_link

sources:
  - files:
      - rtl/rtc_pkg.sv
      - rtl/spi_byte_if.sv
      - rtl/spi_byte_engine.sv
      - rtl/ce_framer.sv
      - rtl/rtc_access_seq.sv
      - rtl/rtc_link.sv
  - target: test
    files:
      - verification/rtc_link_properties.sv
      - verification/rtc_link_checker.sv
      - verification/rtc_link_tb.sv

//--- rtl/ce_framer.sv
`timescale 1ns/1ps

module ce_framer #(
	parameter int CE_SETUP = rtc_pkg::DEF_CE_SETUP,
	parameter int CE_HOLD = rtc_pkg::DEF_CE_HOLD
) (
	input  logic clk,
	input  logic reset_n,
	input  logic open,
	input  logic close,
	output logic ce,
	output logic ready
);

	localparam int CNT_MAX = (CE_SETUP > CE_HOLD) ? CE_SETUP : CE_HOLD;
	localparam int CNT_W = $clog2(CNT_MAX + 1);

	logic [CNT_W-1:0] cnt;
	logic             closing;

	// One counter serves both setup and hold. A zero count means no wait is running.
	// Both counts are expected to be at least one.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			cnt <= '0;
			closing <= 1'b0;
			ce <= 1'b0;
			ready <= 1'b0;
		end else begin
			ready <= 1'b0;
			if (open) begin
				cnt <= CNT_W'(CE_SETUP);
				closing <= 1'b0;
				ce <= 1'b1;
			end else if (close) begin
				cnt <= CNT_W'(CE_HOLD);
				closing <= 1'b1;
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
				if (cnt == CNT_W'(1)) begin
					ready <= 1'b1;
					// Chip enable drops with the last ready of the access.
					if (closing) begin
						ce <= 1'b0;
					end
				end
			end
		end
	end

endmodule

//--- rtl/rtc_access_seq.sv
`timescale 1ns/1ps

module rtc_access_seq (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        req,
	input  logic        write,
	input  logic        ram_sel,
	input  logic [4:0]  addr,
	input  logic [7:0]  wdata,
	spi_byte_if.master  bus,
	output logic        open,
	output logic        close,
	input  logic        ready,
	output logic        ack,
	output logic        busy,
	output logic [7:0]  rdata
);

	import rtc_pkg::*;

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_OPEN = 3'd1;
	localparam logic [2:0] S_CMD = 3'd2;
	localparam logic [2:0] S_GAP = 3'd3;
	localparam logic [2:0] S_DATA = 3'd4;
	localparam logic [2:0] S_CLOSE = 3'd5;

	logic [2:0] state;
	rtc_cmd_u   cmd;
	logic [7:0] wdata_q;

	assign busy = (state != S_IDLE);

	always_ff @(posedge clk) begin
		if (state == S_IDLE && req) begin
			cmd.fields.start <= 1'b1;
			cmd.fields.ram_sel <= ram_sel;
			cmd.fields.addr <= addr;
			cmd.fields.rd <= write ? ACC_WRITE : ACC_READ;
			wdata_q <= wdata;
		end
		if (state == S_OPEN && ready) begin
			bus.tx_byte <= cmd.raw;
		end else if (state == S_GAP && !bus.busy) begin
			// A read clocks out zeros while the chip drives its byte back.
			bus.tx_byte <= (cmd.fields.rd == ACC_READ) ? 8'h00 : wdata_q;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= S_IDLE;
			open <= 1'b0;
			close <= 1'b0;
			bus.start <= 1'b0;
			ack <= 1'b0;
			rdata <= '0;
		end else begin
			open <= 1'b0;
			close <= 1'b0;
			bus.start <= 1'b0;
			ack <= 1'b0;
			case (state)
				S_IDLE: begin
					if (req) begin
						open <= 1'b1;
						state <= S_OPEN;
					end
				end
				S_OPEN: begin
					if (ready) begin
						bus.start <= 1'b1;
						state <= S_CMD;
					end
				end
				S_CMD: begin
					if (bus.done) begin
						state <= S_GAP;
					end
				end
				// The engine stays busy for its gap cycle after done.
				S_GAP: begin
					if (!bus.busy) begin
						bus.start <= 1'b1;
						state <= S_DATA;
					end
				end
				S_DATA: begin
					if (bus.done) begin
						close <= 1'b1;
						state <= S_CLOSE;
					end
				end
				S_CLOSE: begin
					if (ready) begin
						ack <= 1'b1;
						state <= S_IDLE;
						if (cmd.fields.rd == ACC_READ) begin
							rdata <= bus.rx_byte;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

//--- rtl/rtc_link.sv
`timescale 1ns/1ps

module rtc_link #(
	parameter int CE_SETUP = rtc_pkg::DEF_CE_SETUP,
	parameter int CE_HOLD = rtc_pkg::DEF_CE_HOLD
) (
	input  logic                         clk,
	input  logic                         reset_n,
	input  logic                         req,
	input  logic                         write,
	input  logic                         ram_sel,
	input  logic [4:0]                   addr,
	input  logic [7:0]                   wdata,
	input  logic [rtc_pkg::CLK_DIV_W-1:0] clk_div,
	output logic                         ack,
	output logic                         busy,
	output logic [7:0]                   rdata,
	output logic                         ce,
	output logic                         sclk,
	output logic                         sdo,
	input  logic                         sdi
);

	logic ce_open;
	logic ce_close;
	logic ce_ready;

	spi_byte_if byte_bus ();

	spi_byte_engine #(
		.CLK_DIV_W(rtc_pkg::CLK_DIV_W)
	) spi_byte_engine_i (
		.clk(clk),
		.reset_n(reset_n),
		.clk_div(clk_div),
		.bus(byte_bus.engine),
		.sclk(sclk),
		.sdo(sdo),
		.sdi(sdi)
	);

	ce_framer #(
		.CE_SETUP(CE_SETUP),
		.CE_HOLD(CE_HOLD)
	) ce_framer_i (
		.clk(clk),
		.reset_n(reset_n),
		.open(ce_open),
		.close(ce_close),
		.ce(ce),
		.ready(ce_ready)
	);

	rtc_access_seq rtc_access_seq_i (
		.clk(clk),
		.reset_n(reset_n),
		.req(req),
		.write(write),
		.ram_sel(ram_sel),
		.addr(addr),
		.wdata(wdata),
		.bus(byte_bus.master),
		.open(ce_open),
		.close(ce_close),
		.ready(ce_ready),
		.ack(ack),
		.busy(busy),
		.rdata(rdata)
	);

endmodule

//--- rtl/rtc_pkg.sv
package rtc_pkg;

	// Serial clock divider width. The half period of sclk is clk_div+2 cycles.
	localparam int CLK_DIV_W = 16;

	// Chip enable setup and hold, in system clock cycles.
	localparam int DEF_CE_SETUP = 8;
	localparam int DEF_CE_HOLD = 8;

	// Access kind as it appears in bit 0 of the command byte.
	localparam logic ACC_WRITE = 1'b0;
	localparam logic ACC_READ = 1'b1;

	// Command byte fields, MSB first on the wire.
	// The start bit must always be one or the chip ignores the access.
	typedef struct packed {
		logic       start;
		logic       ram_sel;
		logic [4:0] addr;
		logic       rd;
	} rtc_cmd_fields_s;

	// The sequencer fills the fields and the byte engine shifts the raw bits.
	typedef union packed {
		rtc_cmd_fields_s fields;
		logic [7:0]      raw;
	} rtc_cmd_u;

endpackage

//--- rtl/spi_byte_engine.sv
`timescale 1ns/1ps

module spi_byte_engine #(
	parameter int CLK_DIV_W = rtc_pkg::CLK_DIV_W
) (
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic [CLK_DIV_W-1:0] clk_div,
	spi_byte_if.engine           bus,
	output logic                 sclk,
	output logic                 sdo,
	input  logic                 sdi
);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_WAIT = 3'd1;
	localparam logic [2:0] S_EDGE = 3'd2;
	localparam logic [2:0] S_HALF = 3'd3;
	localparam logic [2:0] S_DONE = 3'd4;
	localparam logic [2:0] S_GAP = 3'd5;

	logic [2:0]           state;
	logic [2:0]           next_state;
	logic [CLK_DIV_W-1:0] div_cnt;
	logic [3:0]           edge_cnt;
	logic [7:0]           tx_shift;
	logic [7:0]           rx_shift;

	assign bus.done = (state == S_DONE);
	assign bus.busy = (state != S_IDLE);
	assign bus.rx_byte = rx_shift;
	assign sdo = tx_shift[7];

	// Divider runs through the wait state and the closing half period.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			div_cnt <= '0;
		end else if (state == S_WAIT || state == S_HALF) begin
			div_cnt <= div_cnt + 1'b1;
		end else begin
			div_cnt <= '0;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			edge_cnt <= '0;
		end else if (state == S_IDLE) begin
			edge_cnt <= '0;
		end else if (state == S_EDGE) begin
			edge_cnt <= edge_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			sclk <= 1'b0;
		end else if (state == S_EDGE) begin
			sclk <= ~sclk;
		end
	end

	// Even edges are rising ones, so sdi is taken there.
	// Odd edges fall and move the next bit onto sdo.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rx_shift <= '0;
		end else if (state == S_IDLE && bus.start) begin
			rx_shift <= '0;
		end else if (state == S_EDGE && !edge_cnt[0]) begin
			rx_shift <= {rx_shift[6:0], sdi};
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			tx_shift <= '0;
		end else if (state == S_IDLE && bus.start) begin
			tx_shift <= bus.tx_byte;
		end else if (state == S_EDGE && edge_cnt[0]) begin
			tx_shift <= {tx_shift[6:0], tx_shift[7]};
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= S_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE: if (bus.start) next_state = S_WAIT;
			S_WAIT: if (div_cnt == clk_div) next_state = S_EDGE;
			S_EDGE: next_state = (edge_cnt == 4'd15) ? S_HALF : S_WAIT;
			S_HALF: if (div_cnt == clk_div) next_state = S_DONE;
			S_DONE: next_state = S_GAP;
			S_GAP: next_state = S_IDLE;
			default: next_state = S_IDLE;
		endcase
	end

endmodule

//--- rtl/spi_byte_if.sv
`timescale 1ns/1ps

interface spi_byte_if;

	logic       start;
	logic [7:0] tx_byte;
	logic [7:0] rx_byte;
	logic       done;
	logic       busy;

	// Start is pulsed only while busy is low, and tx_byte is taken in that cycle.
	modport master (
		output start,
		output tx_byte,
		input  rx_byte,
		input  done,
		input  busy
	);

	modport engine (
		input  start,
		input  tx_byte,
		output rx_byte,
		output done,
		output busy
	);

endinterface

//--- verification/rtc_link_checker.sv
`timescale 1ns/1ps

module rtc_link_checker (
	input logic                          clk,
	input logic                          reset_n,
	input logic                          req,
	input logic                          write,
	input logic                          ram_sel,
	input logic [4:0]                    addr,
	input logic [7:0]                    wdata,
	input logic [rtc_pkg::CLK_DIV_W-1:0] clk_div,
	input logic                          ack,
	input logic                          busy,
	input logic [7:0]                    rdata,
	input logic                          ce,
	input logic                          sclk,
	input logic                          sdo
);

	logic [7:0]  regs [64];
	logic [7:0]  exp_rdata;
	logic [15:0] exp_bits;
	logic [15:0] bits_seen;
	logic [5:0]  edges;
	logic        pending;
	logic        out_of_reset;
	logic        sclk_q;
	logic        ce_q;
	int          half;
	int          since;
	int          error_count = 0;
	int          check_count = 0;

	function automatic logic [7:0] initial_reg_value(input int idx);
		return 8'(idx * 37) ^ 8'h5c;
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		error_count++;
		$display("Checker: %s", what);
	endtask

	always @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < 64; i++) begin
				regs[i] <= initial_reg_value(i);
			end
			exp_rdata <= '0;
			pending <= 1'b0;
			out_of_reset <= 1'b0;
			sclk_q <= 1'b0;
			ce_q <= 1'b0;
			edges <= '0;
			since <= 0;
		end else begin
			out_of_reset <= 1'b1;
			sclk_q <= sclk;
			ce_q <= ce;
			since <= since + 1;
			if (!out_of_reset) begin
				compare("ce", ce, 0);
				compare("sclk", sclk, 0);
				compare("ack", ack, 0);
			end
			if (sclk != sclk_q) begin
				if (!ce) begin
					report_failure("sclk toggled while ce was low");
				end
				// The first edge of each byte comes after a longer gap.
				if (edges[3:0] != 4'd0) begin
					compare("sclk half period", since, half);
				end
				if (sclk) begin
					bits_seen <= {bits_seen[14:0], sdo};
				end
				edges <= edges + 1'b1;
				since <= 1;
			end
			if (ce_q && !ce) begin
				compare("sclk edges", edges, 32);
				compare("sdo command byte", bits_seen[15:8], exp_bits[15:8]);
				compare("sdo data byte", bits_seen[7:0], exp_bits[7:0]);
				edges <= '0;
			end
			if (ack) begin
				if (!pending) begin
					report_failure("ack came without an accepted request");
				end
				compare("rdata", rdata, exp_rdata);
				pending <= 1'b0;
			end
			if (req && !busy) begin
				if (pending && !ack) begin
					report_failure("a request was accepted before the previous ack");
				end
				pending <= 1'b1;
				half <= int'(clk_div) + 2;
				exp_bits <= {1'b1, ram_sel, addr, !write, write ? wdata : 8'h00};
				// A write leaves rdata at the value of the last read.
				if (write) begin
					regs[{ram_sel, addr}] <= wdata;
				end else begin
					exp_rdata <= regs[{ram_sel, addr}];
				end
			end
		end
	end

endmodule

//--- verification/rtc_link_properties.sv
`timescale 1ns/1ps

module rtc_link_properties (
	input logic clk,
	input logic reset_n,
	input logic ack,
	input logic busy,
	input logic ce,
	input logic sclk
);

	int failures = 0;

	ack_one_cycle: assert property (@(posedge clk) disable iff (!reset_n) ack |=> !ack)
	else begin
		failures++;
		$error("ack stayed high for more than one cycle");
	end

	// Busy drops in exactly the cycle that carries ack.
	busy_falls_with_ack: assert property (@(posedge clk) disable iff (!reset_n)
		ack == $fell(busy))
	else begin
		failures++;
		$error("busy and ack are out of step");
	end

	ce_covers_sclk: assert property (@(posedge clk) disable iff (!reset_n) sclk |-> ce)
	else begin
		failures++;
		$error("sclk was high while ce was low");
	end

endmodule

bind rtc_link rtc_link_properties rtc_link_properties_i (.*);

//--- verification/rtc_link_tb.sv
`timescale 1ns/1ps

module rtc_link_tb;

	import rtc_pkg::*;

	localparam int NUM_ACCESSES = 200;
	localparam int MAX_DIV = 5;
	// Two bytes at the slowest divider, chip enable setup and hold, and idle cycles between.
	localparam int ACCESS_MAX = 2 * (16 * (MAX_DIV + 2) + MAX_DIV + 3)
		+ DEF_CE_SETUP + DEF_CE_HOLD + 16;
	localparam int CYCLE_LIMIT = 16 + NUM_ACCESSES * ACCESS_MAX + 100;

	logic                 clk;
	logic                 reset_n;
	logic                 req;
	logic                 write;
	logic                 ram_sel;
	logic [4:0]           addr;
	logic [7:0]           wdata;
	logic [CLK_DIV_W-1:0] clk_div;
	logic                 ack;
	logic                 busy;
	logic [7:0]           rdata;
	logic                 ce;
	logic                 sclk;
	logic                 sdo;
	logic                 sdi = 1'b0;

	logic [31:0] rng_state;
	int          cycles = 0;
	int          accesses = 0;
	int          total_errors;

	logic [7:0] chip_mem [64];
	logic       sclk_q;
	logic       ce_q;
	logic [4:0] rise_cnt;
	logic [7:0] cmd_sr;
	logic [7:0] data_sr;

	rtc_link #(
		.CE_SETUP(DEF_CE_SETUP),
		.CE_HOLD(DEF_CE_HOLD)
	) rtc_link_i (.*);

	rtc_link_checker checker_i (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [7:0] initial_reg_value(input int idx);
		return 8'(idx * 37) ^ 8'h5c;
	endfunction

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Chip model. Bits come in on rising sclk, read data goes out on falling sclk.
	always @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < 64; i++) begin
				chip_mem[i] <= initial_reg_value(i);
			end
			sclk_q <= 1'b0;
			ce_q <= 1'b0;
			rise_cnt <= '0;
			cmd_sr <= '0;
			data_sr <= '0;
			sdi <= 1'b0;
		end else begin
			sclk_q <= sclk;
			ce_q <= ce;
			if (!ce) begin
				rise_cnt <= '0;
				if (ce_q && !cmd_sr[0] && rise_cnt == 5'd16) begin
					chip_mem[cmd_sr[6:1]] <= data_sr;
				end
			end else if (sclk && !sclk_q) begin
				rise_cnt <= rise_cnt + 1'b1;
				if (rise_cnt < 5'd8) begin
					cmd_sr <= {cmd_sr[6:0], sdo};
				end else begin
					data_sr <= {data_sr[6:0], sdo};
				end
			end else if (!sclk && sclk_q && cmd_sr[0] && rise_cnt[4:3] == 2'b01) begin
				// Rising edges 8 to 15 take data bits 7 down to 0.
				sdi <= chip_mem[cmd_sr[6:1]][~rise_cnt[2:0]];
			end
		end
	end

	task automatic run_access();
		logic [31:0] r;
		rng_state = xorshift(rng_state);
		r = rng_state;
		repeat (r[25:24]) @(posedge clk);
		@(posedge clk);
		req <= 1'b1;
		write <= r[0];
		ram_sel <= r[1];
		addr <= r[6:2];
		wdata <= r[15:8];
		clk_div <= CLK_DIV_W'(r[18:16] % 6);
		@(posedge clk);
		req <= 1'b0;
		// A stray request in the middle of the access has to be ignored.
		if (r[20]) begin
			@(posedge clk);
			req <= 1'b1;
			write <= r[21];
			addr <= r[31:27];
			@(posedge clk);
			req <= 1'b0;
		end
		do begin
			@(posedge clk);
		end while (!ack);
		accesses++;
	endtask

	initial begin
		rng_state = 32'h6788_f943;
		reset_n = 1'b0;
		req = 1'b0;
		write = 1'b0;
		ram_sel = 1'b0;
		addr = '0;
		wdata = '0;
		clk_div = '0;
		repeat (16) @(posedge clk);
		reset_n <= 1'b1;
		repeat (NUM_ACCESSES) run_access();
		repeat (4) @(posedge clk);
		total_errors = checker_i.error_count + rtc_link_i.rtc_link_properties_i.failures;
		$display("Accesses %0d, checks %0d, check errors %0d, assertion failures %0d",
			accesses, checker_i.check_count, checker_i.error_count,
			rtc_link_i.rtc_link_properties_i.failures);
		if (total_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles, %0d accesses completed",
			CYCLE_LIMIT, accesses);
		$display("Regression failed");
		$finish;
	end

endmodule

//--- vlog.f
rtl/rtc_pkg.sv
rtl/spi_byte_if.sv
rtl/spi_byte_engine.sv
rtl/ce_framer.sv
rtl/rtc_access_seq.sv
rtl/rtc_link.sv
verification/rtc_link_properties.sv
verification/rtc_link_checker.sv
verification/rtc_link_tb.sv
